// ==== rtl/axis_pkg.sv ====
// ======================================
// byte stream types shared by all ports
// ======================================

package axis_pkg;

    // one stream beat, a single byte plus frame markers
    typedef struct packed {
        // payload byte
        logic [7:0] data;
        // final byte of the frame
        logic       last;
        // frame is bad, meaningful with last
        logic       user;
    } axis_beat_t;

endpackage

// ==== rtl/eth_pkg.sv ====
// ======================================
// ethernet frame header layout, lengths
// and the CRC-32 byte update
// ======================================

package eth_pkg;

    // header and check sequence sizes in octets
    localparam int HDR_LEN = 14;
    localparam int FCS_LEN = 4;

    // CRC-32, polynomial 0x04C11DB7 in bit-reversed form
    localparam logic [31:0] CRC32_POLY_REFL = 32'hEDB8_8320;
    localparam logic [31:0] CRC32_INIT      = 32'hFFFF_FFFF;

    // header as named fields, dest_mac lands in the top bits
    typedef struct packed {
        logic [47:0] dest_mac;
        logic [47:0] src_mac;
        logic [15:0] eth_type;
    } eth_hdr_fields_t;

    // same 112 bits seen as octets, octet 0 goes out first
    typedef union packed {
        eth_hdr_fields_t               fields;
        logic [0:HDR_LEN-1][7:0]       octets;
    } eth_hdr_t;

    // advance a reflected CRC-32 by one byte, lsb first
    function automatic logic [31:0] crc32_byte(
        input logic [31:0] crc,
        input logic [7:0]  data
    );
        logic [31:0] c;
        c = crc ^ {24'd0, data};
        for (int i = 0; i < 8; i++) begin
            if (c[0]) begin
                c = (c >> 1) ^ CRC32_POLY_REFL;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

endpackage

// ==== rtl/axis_skid_reg.sv ====
// ======================================
// axis_skid_reg: two-entry output stage
// with a registered ready
// ======================================

`timescale 1ns/100ps

module axis_skid_reg (
    input  logic                 clk,
    input  logic                 rst,
    input  axis_pkg::axis_beat_t s_beat,
    input  logic                 s_valid,
    output logic                 s_ready,
    output axis_pkg::axis_beat_t m_beat,
    output logic                 m_valid,
    input  logic                 m_ready
);

    axis_pkg::axis_beat_t out_beat;
    axis_pkg::axis_beat_t tmp_beat;
    logic                 out_valid;
    logic                 tmp_valid;
    logic                 ready_reg;
    logic                 ready_early;

    assign s_ready = ready_reg;
    assign m_beat  = out_beat;
    assign m_valid = out_valid;

    // ready next cycle unless the temp slot could fill up
    assign ready_early = m_ready || (!tmp_valid && (!out_valid || !s_valid));

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            tmp_valid <= 1'b0;
            ready_reg <= 1'b0;
        end else begin
            ready_reg <= ready_early;
            if (ready_reg) begin
                if (m_ready || !out_valid) begin
                    out_valid <= s_valid;
                end else begin
                    // park the beat while the output is stalled
                    tmp_valid <= s_valid;
                end
            end else if (m_ready) begin
                out_valid <= tmp_valid;
                tmp_valid <= 1'b0;
            end
        end
    end

    // beat storage for the output and temp slots
    always_ff @(posedge clk) begin
        if (ready_reg) begin
            if (m_ready || !out_valid) begin
                out_beat <= s_beat;
            end else begin
                tmp_beat <= s_beat;
            end
        end else if (m_ready) begin
            out_beat <= tmp_beat;
        end
    end

endmodule

// ==== rtl/eth_hdr_tx.sv ====
// ======================================
// eth_hdr_tx: sends 14 header octets,
// then forwards the payload stream
// ======================================

`timescale 1ns/100ps

module eth_hdr_tx (
    input  logic                 clk,
    input  logic                 rst,
    input  eth_pkg::eth_hdr_t    s_hdr,
    input  logic                 s_hdr_valid,
    output logic                 s_hdr_ready,
    input  axis_pkg::axis_beat_t s_payload,
    input  logic                 s_payload_valid,
    output logic                 s_payload_ready,
    output axis_pkg::axis_beat_t m_beat,
    output logic                 m_valid,
    input  logic                 m_ready,
    output logic                 busy
);

    localparam int PTR_W = $clog2(eth_pkg::HDR_LEN);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(eth_pkg::HDR_LEN - 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_HEADER,
        ST_PAYLOAD
    } state_t;

    state_t               state;
    state_t               state_next;
    logic [PTR_W-1:0]     ptr;
    logic [PTR_W-1:0]     ptr_next;
    eth_pkg::eth_hdr_t    hdr_reg;
    logic                 store_hdr;
    logic                 hdr_ready_reg;
    logic                 busy_reg;

    // stream into the output stage
    axis_pkg::axis_beat_t int_beat;
    logic                 int_valid;
    logic                 int_ready;

    assign s_hdr_ready     = hdr_ready_reg;
    assign s_payload_ready = (state == ST_PAYLOAD) && int_ready;
    assign busy            = busy_reg;

    always_comb begin
        state_next = state;
        ptr_next   = ptr;
        store_hdr  = 1'b0;
        int_beat   = '0;
        int_valid  = 1'b0;

        case (state)
            ST_IDLE: begin
                ptr_next = '0;
                if (s_hdr_valid && hdr_ready_reg) begin
                    store_hdr  = 1'b1;
                    state_next = ST_HEADER;
                end
            end
            ST_HEADER: begin
                // octet view of the latched header
                int_valid     = 1'b1;
                int_beat.data = hdr_reg.octets[ptr];
                if (int_ready) begin
                    ptr_next = ptr + 1'b1;
                    if (ptr == LAST_PTR) begin
                        state_next = ST_PAYLOAD;
                    end
                end
            end
            ST_PAYLOAD: begin
                int_beat  = s_payload;
                int_valid = s_payload_valid;
                if (s_payload_valid && s_payload_ready && s_payload.last) begin
                    state_next = ST_IDLE;
                end
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= ST_IDLE;
            ptr           <= '0;
            hdr_ready_reg <= 1'b0;
            busy_reg      <= 1'b0;
        end else begin
            state         <= state_next;
            ptr           <= ptr_next;
            // header port only open while idle
            hdr_ready_reg <= (state_next == ST_IDLE);
            busy_reg      <= (state_next != ST_IDLE);
        end
    end

    // capture by field
    always_ff @(posedge clk) begin
        if (store_hdr) begin
            hdr_reg.fields <= s_hdr.fields;
        end
    end

    axis_skid_reg out_reg_i (
        .clk     (clk),
        .rst     (rst),
        .s_beat  (int_beat),
        .s_valid (int_valid),
        .s_ready (int_ready),
        .m_beat  (m_beat),
        .m_valid (m_valid),
        .m_ready (m_ready)
    );

endmodule

// ==== rtl/eth_fcs_insert.sv ====
// ======================================
// eth_fcs_insert: pads short frames and
// appends the CRC-32 check sequence
// ======================================

`timescale 1ns/100ps

module eth_fcs_insert #(
    parameter int MIN_FRAME_LEN = 60
) (
    input  logic                 clk,
    input  logic                 rst,
    input  axis_pkg::axis_beat_t s_beat,
    input  logic                 s_valid,
    output logic                 s_ready,
    output axis_pkg::axis_beat_t m_beat,
    output logic                 m_valid,
    input  logic                 m_ready
);

    localparam int CNT_W     = $clog2(MIN_FRAME_LEN + 1);
    localparam int FCS_PTR_W = $clog2(eth_pkg::FCS_LEN);
    localparam logic [CNT_W-1:0] MIN_CNT = CNT_W'(MIN_FRAME_LEN);

    typedef enum logic [1:0] {
        ST_DATA,
        ST_PAD,
        ST_FCS
    } state_t;

    state_t               state;
    logic [CNT_W-1:0]     byte_cnt;
    logic [CNT_W-1:0]     cnt_inc;
    logic [FCS_PTR_W-1:0] fcs_ptr;
    logic                 fcs_last;
    logic [31:0]          crc;
    logic [31:0]          fcs_word;
    logic                 user_reg;

    axis_pkg::axis_beat_t int_beat;
    logic                 int_valid;
    logic                 int_ready;
    logic                 int_xfer;

    // input closed while pad and fcs bytes go out
    assign s_ready  = (state == ST_DATA) && int_ready;
    assign int_xfer = int_valid && int_ready;

    // count saturates at the minimum length
    assign cnt_inc  = (byte_cnt == MIN_CNT) ? byte_cnt : byte_cnt + 1'b1;
    assign fcs_word = ~crc;
    assign fcs_last = (fcs_ptr == FCS_PTR_W'(eth_pkg::FCS_LEN - 1));

    always_comb begin
        int_beat  = '0;
        int_valid = 1'b0;
        case (state)
            ST_DATA: begin
                // last and user move to the final fcs byte
                int_beat.data = s_beat.data;
                int_valid     = s_valid;
            end
            ST_PAD: begin
                int_valid = 1'b1;
            end
            ST_FCS: begin
                int_valid     = 1'b1;
                int_beat.data = fcs_word[8*fcs_ptr +: 8];
                int_beat.last = fcs_last;
                int_beat.user = fcs_last && user_reg;
            end
            default: begin
                int_valid = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= ST_DATA;
            byte_cnt <= '0;
            fcs_ptr  <= '0;
            crc      <= eth_pkg::CRC32_INIT;
            user_reg <= 1'b0;
        end else if (int_xfer) begin
            case (state)
                ST_DATA: begin
                    crc      <= eth_pkg::crc32_byte(crc, s_beat.data);
                    byte_cnt <= cnt_inc;
                    if (s_beat.last) begin
                        user_reg <= s_beat.user;
                        fcs_ptr  <= '0;
                        state    <= (cnt_inc < MIN_CNT) ? ST_PAD : ST_FCS;
                    end
                end
                ST_PAD: begin
                    crc      <= eth_pkg::crc32_byte(crc, 8'h00);
                    byte_cnt <= cnt_inc;
                    if (cnt_inc == MIN_CNT) begin
                        state <= ST_FCS;
                    end
                end
                ST_FCS: begin
                    fcs_ptr <= fcs_ptr + 1'b1;
                    if (fcs_last) begin
                        // ready for the next frame
                        crc      <= eth_pkg::CRC32_INIT;
                        byte_cnt <= '0;
                        state    <= ST_DATA;
                    end
                end
                default: begin
                    state <= ST_DATA;
                end
            endcase
        end
    end

    axis_skid_reg out_reg_i (
        .clk     (clk),
        .rst     (rst),
        .s_beat  (int_beat),
        .s_valid (int_valid),
        .s_ready (int_ready),
        .m_beat  (m_beat),
        .m_valid (m_valid),
        .m_ready (m_ready)
    );

endmodule

// ==== rtl/eth_tx_top.sv ====
// ======================================
// eth_tx_top: ethernet transmit chain,
// header merge then pad and FCS
// ======================================

`timescale 1ns/100ps

module eth_tx_top #(
    parameter int MIN_FRAME_LEN = 60
) (
    input  logic                 clk,
    input  logic                 rst,
    input  eth_pkg::eth_hdr_t    s_hdr,
    input  logic                 s_hdr_valid,
    output logic                 s_hdr_ready,
    input  axis_pkg::axis_beat_t s_payload,
    input  logic                 s_payload_valid,
    output logic                 s_payload_ready,
    output axis_pkg::axis_beat_t m_frame,
    output logic                 m_frame_valid,
    input  logic                 m_frame_ready,
    output logic                 busy
);

    // header plus payload, before padding
    axis_pkg::axis_beat_t hdr_stream;
    logic                 hdr_stream_valid;
    logic                 hdr_stream_ready;

    eth_hdr_tx hdr_tx_i (
        .clk             (clk),
        .rst             (rst),
        .s_hdr           (s_hdr),
        .s_hdr_valid     (s_hdr_valid),
        .s_hdr_ready     (s_hdr_ready),
        .s_payload       (s_payload),
        .s_payload_valid (s_payload_valid),
        .s_payload_ready (s_payload_ready),
        .m_beat          (hdr_stream),
        .m_valid         (hdr_stream_valid),
        .m_ready         (hdr_stream_ready),
        .busy            (busy)
    );

    eth_fcs_insert #(
        .MIN_FRAME_LEN (MIN_FRAME_LEN)
    ) fcs_insert_i (
        .clk     (clk),
        .rst     (rst),
        .s_beat  (hdr_stream),
        .s_valid (hdr_stream_valid),
        .s_ready (hdr_stream_ready),
        .m_beat  (m_frame),
        .m_valid (m_frame_valid),
        .m_ready (m_frame_ready)
    );

endmodule

// ==== verif/eth_tx_sva.sv ====
// ======================================
// eth_tx_sva: handshake checks on the
// transmit chain ports
// ======================================

`timescale 1ns/100ps

module eth_tx_sva (
    input logic                 clk,
    input logic                 rst,
    input logic                 s_payload_valid,
    input logic                 s_payload_ready,
    input axis_pkg::axis_beat_t m_frame,
    input logic                 m_frame_valid,
    input logic                 m_frame_ready,
    input logic                 busy
);

    // stalled output beat is held
    a_hold_beat: assert property (@(posedge clk) disable iff (rst)
        m_frame_valid && !m_frame_ready |=> m_frame_valid && $stable(m_frame))
        else $error("output beat changed while stalled");

    a_reset_idle: assert property (@(posedge clk) rst |=> !m_frame_valid)
        else $error("output valid right after reset");

    a_busy_payload: assert property (@(posedge clk) disable iff (rst)
        s_payload_valid && s_payload_ready |-> busy)
        else $error("payload accepted while not busy");

endmodule

// ==== verif/eth_tx_tb.sv ====
// ======================================
// eth_tx_tb: vector-driven testbench for
// the ethernet transmit chain
// ======================================

`timescale 1ns/100ps

module eth_tx_tb;

    localparam int MAX_LINES  = 64;
    localparam int MAX_FRAMES = 8;
    localparam int TIMEOUT    = 2000;

    logic                 clk;
    logic                 rst;
    eth_pkg::eth_hdr_t    s_hdr;
    logic                 s_hdr_valid;
    logic                 s_hdr_ready;
    axis_pkg::axis_beat_t s_payload;
    logic                 s_payload_valid;
    logic                 s_payload_ready;
    axis_pkg::axis_beat_t m_frame;
    logic                 m_frame_valid;
    logic                 m_frame_ready;
    logic                 busy;

    logic [111:0]      vec_mem [0:MAX_LINES-1];
    eth_pkg::eth_hdr_t frame_hdr [MAX_FRAMES];
    int                pay_len [MAX_FRAMES];
    int                pay_line [MAX_FRAMES];
    int                exp_len [MAX_FRAMES];
    logic              frame_user [MAX_FRAMES];
    int                num_frames;
    int                errors;
    integer            seed;

    eth_tx_top #(.MIN_FRAME_LEN(60)) dut_i (.*);

    bind eth_tx_top eth_tx_sva sva_i (
        .clk             (clk),
        .rst             (rst),
        .s_payload_valid (s_payload_valid),
        .s_payload_ready (s_payload_ready),
        .m_frame         (m_frame),
        .m_frame_valid   (m_frame_valid),
        .m_frame_ready   (m_frame_ready),
        .busy            (busy)
    );

    always #20 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    // payload bytes sit 14 per line with the first byte in the top octet
    function automatic logic [7:0] payload_byte(input int f, input int k);
        logic [111:0] line;
        line = vec_mem[pay_line[f] + k / 14];
        return line[111 - 8 * (k % 14) -: 8];
    endfunction

    // reflected CRC-32 stepped one data bit at a time
    function automatic logic [31:0] crc_step(input logic [31:0] crc, input logic [7:0] b);
        logic fb;
        for (int i = 0; i < 8; i++) begin
            fb  = crc[0] ^ b[i];
            crc = crc >> 1;
            if (fb) begin
                crc = crc ^ 32'hEDB8_8320;
            end
        end
        return crc;
    endfunction

    task automatic load_vectors();
        int line;
        $readmemh("verif/eth_tx_vectors.txt", vec_mem);
        num_frames = int'(vec_mem[0]);
        line       = 1;
        for (int f = 0; f < num_frames; f++) begin
            frame_hdr[f]  = vec_mem[line];
            pay_len[f]    = int'(vec_mem[line + 1][39:24]);
            frame_user[f] = vec_mem[line + 1][16];
            exp_len[f]    = int'(vec_mem[line + 1][15:0]);
            pay_line[f]   = line + 2;
            line          = line + 2 + (pay_len[f] + 13) / 14;
        end
    endtask

    task automatic send_headers();
        int wait_cnt;
        for (int f = 0; f < num_frames; f++) begin
            s_hdr       = frame_hdr[f];
            s_hdr_valid = 1'b1;
            wait_cnt    = 0;
            #1;
            while (!s_hdr_ready && wait_cnt < TIMEOUT) begin
                @(posedge clk);
                #3;
                wait_cnt++;
            end
            if (wait_cnt >= TIMEOUT) begin
                $display("header %0d was never accepted", f);
                errors++;
                break;
            end
            @(posedge clk);
            #2;
        end
        s_hdr_valid = 1'b0;
    endtask

    task automatic send_payloads();
        int wait_cnt;
        for (int f = 0; f < num_frames; f++) begin
            for (int k = 0; k < pay_len[f]; k++) begin
                s_payload.data  = payload_byte(f, k);
                s_payload.last  = (k == pay_len[f] - 1);
                s_payload.user  = s_payload.last && frame_user[f];
                s_payload_valid = 1'b1;
                wait_cnt        = 0;
                #1;
                while (!s_payload_ready && wait_cnt < TIMEOUT) begin
                    @(posedge clk);
                    #3;
                    wait_cnt++;
                end
                if (wait_cnt >= TIMEOUT) begin
                    $display("payload byte %0d of frame %0d was never accepted", k, f);
                    errors++;
                    s_payload_valid = 1'b0;
                    return;
                end
                @(posedge clk);
                #2;
            end
        end
        s_payload_valid = 1'b0;
    endtask

    task automatic collect_frames();
        int           idx;
        int           wait_cnt;
        int           err_start;
        logic         done;
        logic [31:0]  crc;
        logic [7:0]   exp_byte;
        logic [31:0]  fcs;
        logic [111:0] hdr_bits;
        for (int f = 0; f < num_frames; f++) begin
            idx       = 0;
            wait_cnt  = 0;
            done      = 1'b0;
            crc       = 32'hFFFF_FFFF;
            err_start = errors;
            // header leaves in vector order, top octet first
            hdr_bits  = frame_hdr[f];
            while (!done && wait_cnt < TIMEOUT) begin
                @(posedge clk);
                #2;
                m_frame_ready = (($random(seed) & 3) != 0);
                #1;
                if (m_frame_valid && m_frame_ready) begin
                    fcs = ~crc;
                    if (idx < eth_pkg::HDR_LEN) begin
                        exp_byte = hdr_bits[111 - 8 * idx -: 8];
                    end else if (idx < eth_pkg::HDR_LEN + pay_len[f]) begin
                        exp_byte = payload_byte(f, idx - eth_pkg::HDR_LEN);
                    end else if (idx < exp_len[f]) begin
                        exp_byte = 8'h00;
                    end else if (idx < exp_len[f] + 4) begin
                        exp_byte = fcs[8 * (idx - exp_len[f]) +: 8];
                    end else begin
                        exp_byte = 8'h00;
                    end
                    check_value("m_frame.data", m_frame.data, exp_byte);
                    check_value("m_frame.last", m_frame.last, idx == exp_len[f] + 3);
                    check_value("m_frame.user", m_frame.user,
                                (idx == exp_len[f] + 3) && frame_user[f]);
                    if (idx < exp_len[f]) begin
                        crc = crc_step(crc, exp_byte);
                    end
                    idx++;
                    wait_cnt = 0;
                    done     = m_frame.last || (idx > exp_len[f] + 4);
                end else begin
                    wait_cnt++;
                end
            end
            if (!done) begin
                $display("frame %0d timed out after %0d output bytes", f, idx);
                errors++;
                break;
            end
            check_value("frame_len", idx, exp_len[f] + 4);
            $display("frame %0d: %0d bytes, %0d errors", f, idx, errors - err_start);
        end
        m_frame_ready = 1'b1;
    endtask

    initial begin
        int wait_cnt;
        clk             = 1'b0;
        rst             = 1'b1;
        s_hdr           = '0;
        s_hdr_valid     = 1'b0;
        s_payload       = '0;
        s_payload_valid = 1'b0;
        m_frame_ready   = 1'b0;
        errors          = 0;
        seed            = 60;
        load_vectors();
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;
        check_value("busy", busy, 1'b0);
        fork
            send_headers();
            send_payloads();
            collect_frames();
        join
        wait_cnt = 0;
        while (busy && wait_cnt < TIMEOUT) begin
            @(posedge clk);
            #3;
            wait_cnt++;
        end
        check_value("busy", busy, 1'b0);
        $display("%0d frames, %0d errors", num_frames, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== verif/eth_tx_vectors.txt ====
// line 1: frame count; per frame: header (dest, src, type), then
// info (payload len _ user _ bytes before fcs), then payload 14 bytes per line
3
ffffffffffff0200000000010800
000a_00_003c
0102030405060708090a00000000
0a1b2c3d4e5f0211223344550806
0032_01_0040
101112131415161718191a1b1c1d
1e1f202122232425262728292a2b
2c2d2e2f30313233343536373839
3a3b3c3d3e3f4041000000000000
00112233445566554433221188b5
002e_00_003c
808182838485868788898a8b8c8d
8e8f909192939495969798999a9b
9c9d9e9fa0a1a2a3a4a5a6a7a8a9
aaabacad00000000000000000000

// ==== build.f ====
rtl/axis_pkg.sv
rtl/eth_pkg.sv
rtl/axis_skid_reg.sv
rtl/eth_hdr_tx.sv
rtl/eth_fcs_insert.sv
rtl/eth_tx_top.sv
verif/eth_tx_sva.sv
verif/eth_tx_tb.sv

// ==== Makefile ====
VERILATOR  = verilator
FLAGS      = --timing --assert
TOP        = eth_tx_tb
FILELIST   = build.f
LOG        = sim.log
OBJ_DIR    = obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
